// ==== src/sys_pkg.sv ====
package sys_pkg;

  // ####################################################################
  // widths and plain vector types
  // ####################################################################

  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;      // data word.
  typedef logic [11:0]     csr_addr_t;  // csr address field.
  typedef logic [4:0]      reg_index_t; // rs1 index or uimm.
  typedef logic [2:0]      funct3_t;

  // ####################################################################
  // zicsr function codes
  // ####################################################################

  localparam funct3_t funct_csrrw  = 3'd1;
  localparam funct3_t funct_csrrs  = 3'd2;
  localparam funct3_t funct_csrrc  = 3'd3;
  localparam funct3_t funct_csrrwi = 3'd5;
  localparam funct3_t funct_csrrsi = 3'd6;
  localparam funct3_t funct_csrrci = 3'd7;

  // ####################################################################
  // csr addresses
  // ####################################################################

  // machine trap setup and handling.
  localparam csr_addr_t csr_mstatus   = 12'h300;
  localparam csr_addr_t csr_mtvec     = 12'h305;
  localparam csr_addr_t csr_mepc      = 12'h341;
  localparam csr_addr_t csr_mcause    = 12'h342;

  // machine counters, low and high halves.
  localparam csr_addr_t csr_mcycle    = 12'hb00;
  localparam csr_addr_t csr_minstret  = 12'hb02;
  localparam csr_addr_t csr_mcycleh   = 12'hb80;
  localparam csr_addr_t csr_minstreth = 12'hb82;

  // machine information, read only.
  localparam csr_addr_t csr_mvendorid = 12'hf11;
  localparam csr_addr_t csr_marchid   = 12'hf12;

  // ####################################################################
  // mstatus fields and trap causes
  // ####################################################################

  localparam int mstatus_mie  = 3;
  localparam int mstatus_mpie = 7;

  localparam word_t cause_illegal = 32'd2;  // illegal instruction.
  localparam word_t cause_ecall_m = 32'd11; // ecall from m-mode.

  // ####################################################################
  // identity constants
  // ####################################################################

  // returned by mvendorid and marchid.
  localparam word_t vendor_id = 32'h0000_0e5a;
  localparam word_t arch_id   = 32'h0000_0017;

endpackage

// ==== src/csr_alu.sv ====
`timescale 1ns/100ps

module csr_alu (
  input  sys_pkg::funct3_t     funct3,
  input  sys_pkg::reg_index_t  src_index,
  input  sys_pkg::word_t       rs1_data,
  input  sys_pkg::word_t       old_value,
  output sys_pkg::word_t       new_value,
  output logic                 write_req
);
  import sys_pkg::*;

  word_t operand;
  logic  src_nonzero;

  // immediate forms take the zero-extended uimm.
  assign operand     = funct3[2] ? word_t'(src_index) : rs1_data;
  assign src_nonzero = (src_index != '0);

  always_comb begin
    new_value = old_value;
    write_req = 1'b0;
    case (funct3)
      funct_csrrw, funct_csrrwi: begin
        new_value = operand;
        write_req = 1'b1;              // write forms always write.
      end
      funct_csrrs, funct_csrrsi: begin
        new_value = old_value | operand;
        write_req = src_nonzero;
      end
      funct_csrrc, funct_csrrci: begin
        new_value = old_value & ~operand;
        write_req = src_nonzero;
      end
      default: begin
        new_value = old_value;         // reserved encodings.
        write_req = 1'b0;
      end
    endcase
  end

endmodule

// ==== src/csr_file.sv ====
`timescale 1ns/100ps

module csr_file (
  input  logic                clock,
  input  logic                reset,
  input  logic                file_wen,
  input  logic                trap,
  input  logic                trap_mret,
  input  sys_pkg::word_t      cause,
  input  sys_pkg::csr_addr_t  addr,
  input  sys_pkg::word_t      wdata,
  input  sys_pkg::word_t      pc,
  output sys_pkg::word_t      rdata,
  output logic                hit,
  output logic                read_only,
  output sys_pkg::word_t      mtvec,
  output sys_pkg::word_t      mepc
);
  import sys_pkg::*;

  word_t mstatus_q;
  word_t mtvec_q;
  word_t mepc_q;
  word_t mcause_q;

  logic sel_mstatus;
  logic sel_mtvec;
  logic sel_mepc;
  logic sel_mcause;
  logic sel_mvendorid;
  logic sel_marchid;

  // ####################################################################
  // address decode and read port
  // ####################################################################

  assign sel_mstatus   = (addr == csr_mstatus);
  assign sel_mtvec     = (addr == csr_mtvec);
  assign sel_mepc      = (addr == csr_mepc);
  assign sel_mcause    = (addr == csr_mcause);
  assign sel_mvendorid = (addr == csr_mvendorid);
  assign sel_marchid   = (addr == csr_marchid);

  assign read_only = sel_mvendorid | sel_marchid;
  assign hit       = sel_mstatus | sel_mtvec | sel_mepc | sel_mcause | read_only;

  always_comb begin
    case (addr)
      csr_mstatus:   rdata = mstatus_q;
      csr_mtvec:     rdata = mtvec_q;
      csr_mepc:      rdata = mepc_q;
      csr_mcause:    rdata = mcause_q;
      csr_mvendorid: rdata = vendor_id;
      csr_marchid:   rdata = arch_id;
      default:       rdata = '0;
    endcase
  end

  // redirect targets for the fetch stage.
  assign mtvec = mtvec_q;
  assign mepc  = mepc_q;

  // ####################################################################
  // register update
  // ####################################################################

  // at most one of file_wen, trap and trap_mret per commit.
  always_ff @(posedge clock) begin
    if (reset) begin
      mstatus_q <= '0;
      mtvec_q   <= '0;
      mepc_q    <= '0;
      mcause_q  <= '0;
    end else begin
      if (file_wen) begin
        if (sel_mstatus) begin
          mstatus_q <= wdata;
        end
        if (sel_mtvec) begin
          mtvec_q <= wdata;
        end
        if (sel_mepc) begin
          mepc_q <= wdata;
        end
        if (sel_mcause) begin
          mcause_q <= wdata;
        end
      end
      if (trap) begin
        mcause_q                <= cause;
        mepc_q                  <= pc;
        mstatus_q[mstatus_mpie] <= mstatus_q[mstatus_mie];
        mstatus_q[mstatus_mie]  <= 1'b0;  // interrupts off on entry.
      end
      if (trap_mret) begin
        mstatus_q[mstatus_mie]  <= mstatus_q[mstatus_mpie];
        mstatus_q[mstatus_mpie] <= 1'b1;
      end
    end
  end

endmodule

// ==== src/csr_counters.sv ====
`timescale 1ns/100ps

module csr_counters (
  input  logic                clock,
  input  logic                reset,
  input  logic                cnt_wen,
  input  logic                retire,
  input  sys_pkg::csr_addr_t  addr,
  input  sys_pkg::word_t      wdata,
  output sys_pkg::word_t      rdata,
  output logic                cnt_hit
);
  import sys_pkg::*;

  logic [2*xlen-1:0] mcycle_q;
  logic [2*xlen-1:0] minstret_q;
  logic [2*xlen-1:0] mcycle_inc;
  logic [2*xlen-1:0] minstret_inc;

  assign mcycle_inc   = mcycle_q + 1'b1;
  assign minstret_inc = minstret_q + retire;

  assign cnt_hit = (addr == csr_mcycle) || (addr == csr_mcycleh) ||
                   (addr == csr_minstret) || (addr == csr_minstreth);

  always_comb begin
    case (addr)
      csr_mcycle:    rdata = mcycle_q[xlen-1:0];
      csr_mcycleh:   rdata = mcycle_q[2*xlen-1:xlen];
      csr_minstret:  rdata = minstret_q[xlen-1:0];
      csr_minstreth: rdata = minstret_q[2*xlen-1:xlen];
      default:       rdata = '0;
    endcase
  end

  // a written half replaces the count, the other half keeps counting.
  always_ff @(posedge clock) begin
    if (reset) begin
      mcycle_q   <= '0;
      minstret_q <= '0;
    end else begin
      mcycle_q   <= mcycle_inc;
      minstret_q <= minstret_inc;
      if (cnt_wen && (addr == csr_mcycle)) mcycle_q[xlen-1:0] <= wdata;
      if (cnt_wen && (addr == csr_mcycleh)) mcycle_q[2*xlen-1:xlen] <= wdata;
      if (cnt_wen && (addr == csr_minstret)) minstret_q[xlen-1:0] <= wdata;
      if (cnt_wen && (addr == csr_minstreth)) minstret_q[2*xlen-1:xlen] <= wdata;
    end
  end

endmodule

// ==== src/sys_ctrl.sv ====
`timescale 1ns/100ps

module sys_ctrl (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 valid,
  input  logic                 ecall,
  input  logic                 mret,
  input  sys_pkg::funct3_t     funct3,
  input  sys_pkg::csr_addr_t   csr_addr,
  input  sys_pkg::reg_index_t  src_index,
  input  sys_pkg::word_t       rs1_data,
  input  sys_pkg::word_t       pc,
  input  sys_pkg::word_t       file_rdata,
  input  sys_pkg::word_t       cnt_rdata,
  input  logic                 hit,
  input  logic                 read_only,
  input  logic                 cnt_hit,
  input  logic                 write_req,
  input  sys_pkg::word_t       new_value,
  input  sys_pkg::word_t       mtvec,
  input  sys_pkg::word_t       mepc,
  output sys_pkg::csr_addr_t   lat_addr,
  output sys_pkg::funct3_t     lat_funct3,
  output sys_pkg::reg_index_t  lat_src_index,
  output sys_pkg::word_t       lat_rs1_data,
  output sys_pkg::word_t       old_value,
  output logic                 file_wen,
  output logic                 cnt_wen,
  output logic                 trap,
  output logic                 trap_mret,
  output logic                 retire,
  output sys_pkg::word_t       cause,
  output sys_pkg::word_t       lat_pc,
  output logic                 busy,
  output logic                 done,
  output logic                 rd_wen,
  output logic                 redirect,
  output sys_pkg::word_t       rd_data,
  output sys_pkg::word_t       redirect_pc
);
  import sys_pkg::*;

  typedef enum logic {
    state_idle,
    state_exec
  } sys_state_t;

  sys_state_t state;
  logic       lat_ecall;
  logic       lat_mret;
  logic       accept;
  logic       in_exec;
  logic       illegal;
  logic       csr_op;

  assign accept  = valid && !busy;
  assign in_exec = (state == state_exec);

  // instruction fields, held for the exec cycle.
  always_ff @(posedge clock) begin
    if (accept) begin
      lat_addr      <= csr_addr;
      lat_funct3    <= funct3;
      lat_src_index <= src_index;
      lat_rs1_data  <= rs1_data;
      lat_pc        <= pc;
    end
  end

  // ####################################################################
  // exec cycle decode
  // ####################################################################

  assign old_value = (hit ? file_rdata : '0) | (cnt_hit ? cnt_rdata : '0);

  // csr fields only matter when neither ecall nor mret is set.
  assign illegal = !lat_ecall && !lat_mret &&
                   ((!hit && !cnt_hit) || (read_only && write_req));
  assign csr_op  = in_exec && !lat_ecall && !lat_mret && !illegal;

  assign trap      = in_exec && (lat_ecall || illegal);
  assign trap_mret = in_exec && lat_mret;
  assign retire    = csr_op || trap_mret;
  assign cause     = illegal ? cause_illegal : cause_ecall_m;

  // skip file writes that would not change the register.
  assign file_wen = csr_op && hit && write_req && (new_value != old_value);
  assign cnt_wen  = csr_op && cnt_hit && write_req;

  // ####################################################################
  // state and registered results
  // ####################################################################

  always_ff @(posedge clock) begin
    if (reset) begin
      state     <= state_idle;
      lat_ecall <= 1'b0;
      lat_mret  <= 1'b0;
      busy      <= 1'b0;
      done      <= 1'b0;
      rd_wen    <= 1'b0;
      redirect  <= 1'b0;
    end else begin
      if (accept) begin
        state     <= state_exec;
        lat_ecall <= ecall;
        lat_mret  <= mret;
      end else if (in_exec) begin
        state <= state_idle;
      end
      busy     <= accept || in_exec; // covers the done cycle too.
      done     <= in_exec;
      rd_wen   <= csr_op;
      redirect <= trap || trap_mret;
    end
  end

  always_ff @(posedge clock) begin
    if (in_exec) begin
      rd_data     <= old_value;
      redirect_pc <= trap ? {mtvec[xlen-1:2], 2'b00} : mepc;
    end
  end

endmodule

// ==== src/exu_sys.sv ====
`timescale 1ns/100ps

module exu_sys (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 valid,
  input  logic                 ecall,
  input  logic                 mret,
  input  sys_pkg::funct3_t     funct3,
  input  sys_pkg::csr_addr_t   csr_addr,
  input  sys_pkg::reg_index_t  src_index,
  input  sys_pkg::word_t       rs1_data,
  input  sys_pkg::word_t       pc,
  output logic                 busy,
  output logic                 done,
  output logic                 rd_wen,
  output sys_pkg::word_t       rd_data,
  output logic                 redirect,
  output sys_pkg::word_t       redirect_pc
);
  import sys_pkg::*;

  // latched instruction fields.
  csr_addr_t  lat_addr;
  funct3_t    lat_funct3;
  reg_index_t lat_src_index;
  word_t      lat_rs1_data;
  word_t      lat_pc;

  // read side.
  word_t file_rdata;
  word_t cnt_rdata;
  logic  hit;
  logic  read_only;
  logic  cnt_hit;
  word_t old_value;
  word_t new_value;
  logic  write_req;

  // commit side.
  logic  file_wen;
  logic  cnt_wen;
  logic  trap;
  logic  trap_mret;
  logic  retire;
  word_t cause;
  word_t mtvec;
  word_t mepc;

  // ####################################################################
  // control
  // ####################################################################

  sys_ctrl i_sys_ctrl (
    .clock         (clock),
    .reset         (reset),
    .valid         (valid),
    .ecall         (ecall),
    .mret          (mret),
    .funct3        (funct3),
    .csr_addr      (csr_addr),
    .src_index     (src_index),
    .rs1_data      (rs1_data),
    .pc            (pc),
    .file_rdata    (file_rdata),
    .cnt_rdata     (cnt_rdata),
    .hit           (hit),
    .read_only     (read_only),
    .cnt_hit       (cnt_hit),
    .write_req     (write_req),
    .new_value     (new_value),
    .mtvec         (mtvec),
    .mepc          (mepc),
    .lat_addr      (lat_addr),
    .lat_funct3    (lat_funct3),
    .lat_src_index (lat_src_index),
    .lat_rs1_data  (lat_rs1_data),
    .old_value     (old_value),
    .file_wen      (file_wen),
    .cnt_wen       (cnt_wen),
    .trap          (trap),
    .trap_mret     (trap_mret),
    .retire        (retire),
    .cause         (cause),
    .lat_pc        (lat_pc),
    .busy          (busy),
    .done          (done),
    .rd_wen        (rd_wen),
    .redirect      (redirect),
    .rd_data       (rd_data),
    .redirect_pc   (redirect_pc)
  );

  // ####################################################################
  // datapath
  // ####################################################################

  csr_alu i_csr_alu (
    .funct3    (lat_funct3),
    .src_index (lat_src_index),
    .rs1_data  (lat_rs1_data),
    .old_value (old_value),
    .new_value (new_value),
    .write_req (write_req)
  );

  csr_file i_csr_file (
    .clock     (clock),
    .reset     (reset),
    .file_wen  (file_wen),
    .trap      (trap),
    .trap_mret (trap_mret),
    .cause     (cause),
    .addr      (lat_addr),
    .wdata     (new_value),
    .pc        (lat_pc),
    .rdata     (file_rdata),
    .hit       (hit),
    .read_only (read_only),
    .mtvec     (mtvec),
    .mepc      (mepc)
  );

  csr_counters i_csr_counters (
    .clock   (clock),
    .reset   (reset),
    .cnt_wen (cnt_wen),
    .retire  (retire),
    .addr    (lat_addr),
    .wdata   (new_value),
    .rdata   (cnt_rdata),
    .cnt_hit (cnt_hit)
  );

endmodule

// ==== verif/exu_sys_tb.sv ====
`timescale 1ns/100ps

module exu_sys_tb;
  import sys_pkg::*;

  typedef struct packed {
    logic  rd_wen;
    word_t rd_data;
    logic  redirect;
    word_t redirect_pc;
  } expected_t;

  localparam int reset_cycles    = 8;
  localparam int done_limit      = 4;
  localparam int n_random_ops    = 40;
  localparam int total_instr     = n_random_ops + 39; // fixed tests add 39.
  localparam int watchdog_cycles = done_limit * total_instr + 200;

  logic       clock;
  logic       reset;
  logic       valid;
  logic       ecall;
  logic       mret;
  funct3_t    funct3;
  csr_addr_t  csr_addr;
  reg_index_t src_index;
  word_t      rs1_data;
  word_t      pc;
  logic       busy;
  logic       done;
  logic       rd_wen;
  word_t      rd_data;
  logic       redirect;
  word_t      redirect_pc;

  word_t       lfsr_state = 32'ha115;
  logic [63:0] cyc;
  expected_t   exp_q[$];
  expected_t   exp_now;
  int          issued_count;
  int          checked_count;
  int          check_count;
  int          error_count;
  int          errors_at_start;
  int          test_count;
  int          failed_tests;

  // reference model state.
  word_t       m_mstatus;
  word_t       m_mtvec;
  word_t       m_mepc;
  word_t       m_mcause;
  logic [63:0] m_minstret;

  exu_sys i_exu_sys (
    .clock       (clock),
    .reset       (reset),
    .valid       (valid),
    .ecall       (ecall),
    .mret        (mret),
    .funct3      (funct3),
    .csr_addr    (csr_addr),
    .src_index   (src_index),
    .rs1_data    (rs1_data),
    .pc          (pc),
    .busy        (busy),
    .done        (done),
    .rd_wen      (rd_wen),
    .rd_data     (rd_data),
    .redirect    (redirect),
    .redirect_pc (redirect_pc)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  // mirrors mcycle, counts every edge out of reset.
  always @(posedge clock) begin
    if (reset) cyc <= '0;
    else       cyc <= cyc + 64'd1;
  end

  // ######################################################################
  // random source and reference model
  // ######################################################################

  function automatic word_t take_bits(input int n);
    word_t bits;
    int    i;
    bits = '0;
    for (i = 0; i < n; i++) begin
      bits = {bits[30:0], lfsr_state[0]};
      if (lfsr_state[0]) lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
      else               lfsr_state = lfsr_state >> 1;
    end
    return bits;
  endfunction

  function automatic word_t random_pc();
    return take_bits(30) << 2;
  endfunction

  function automatic expected_t reference_result(input logic is_ecall, input logic is_mret,
      input funct3_t f3, input csr_addr_t addr, input reg_index_t src, input word_t rs1,
      input word_t pc_val, input logic [63:0] cycle_now);
    expected_t   r;
    word_t       old;
    word_t       operand;
    word_t       next;
    logic        known;
    logic        ro;
    logic        wr;
    logic [63:0] inst_next;
    r     = '0;
    old   = '0;
    known = 1'b1;
    ro    = 1'b0;
    if (is_mret) begin
      r.redirect    = 1'b1;
      r.redirect_pc = m_mepc;
      m_mstatus[mstatus_mie]  = m_mstatus[mstatus_mpie];
      m_mstatus[mstatus_mpie] = 1'b1;
      m_minstret = m_minstret + 64'd1;
      return r;
    end
    case (addr)
      csr_mstatus:   old = m_mstatus;
      csr_mtvec:     old = m_mtvec;
      csr_mepc:      old = m_mepc;
      csr_mcause:    old = m_mcause;
      csr_mcycle:    old = cycle_now[31:0];
      csr_mcycleh:   old = cycle_now[63:32];
      csr_minstret:  old = m_minstret[31:0];
      csr_minstreth: old = m_minstret[63:32];
      csr_mvendorid: begin old = vendor_id; ro = 1'b1; end
      csr_marchid:   begin old = arch_id; ro = 1'b1; end
      default:       known = 1'b0;
    endcase
    operand = f3[2] ? {27'd0, src} : rs1;
    case (f3)
      funct_csrrw, funct_csrrwi: begin next = operand; wr = 1'b1; end
      funct_csrrs, funct_csrrsi: begin next = old | operand; wr = (src != '0); end
      funct_csrrc, funct_csrrci: begin next = old & ~operand; wr = (src != '0); end
      default:                   begin next = old; wr = 1'b0; end
    endcase
    // ecall and illegal share the trap entry.
    if (is_ecall || !known || (ro && wr)) begin
      r.redirect    = 1'b1;
      r.redirect_pc = {m_mtvec[31:2], 2'b00};
      m_mcause = is_ecall ? cause_ecall_m : cause_illegal;
      m_mepc   = pc_val;
      m_mstatus[mstatus_mpie] = m_mstatus[mstatus_mie];
      m_mstatus[mstatus_mie]  = 1'b0;
      return r;
    end
    r.rd_wen  = 1'b1;
    r.rd_data = old;
    inst_next = m_minstret + 64'd1;
    if (wr) begin
      case (addr)
        csr_mstatus:   m_mstatus = next;
        csr_mtvec:     m_mtvec = next;
        csr_mepc:      m_mepc = next;
        csr_mcause:    m_mcause = next;
        csr_minstret:  inst_next[31:0] = next;  // write beats the increment.
        csr_minstreth: inst_next[63:32] = next;
        default: ;
      endcase
    end
    m_minstret = inst_next;
    return r;
  endfunction

  // ######################################################################
  // checking and reporting
  // ######################################################################

  task automatic check_value(input string name, input word_t got, input word_t expected);
    check_count++;
    if (got !== expected) begin
      error_count++;
      $display("Fail %s: got %h, expected %h", name, got, expected);
    end
  endtask

  always @(negedge clock) begin
    if (!reset && done) begin
      if (exp_q.size() == 0) begin
        error_count++;
        $display("done pulsed with no instruction outstanding");
      end else begin
        exp_now = exp_q.pop_front();
        check_value("rd_wen", word_t'(rd_wen), word_t'(exp_now.rd_wen));
        check_value("redirect", word_t'(redirect), word_t'(exp_now.redirect));
        if (exp_now.rd_wen) check_value("rd_data", rd_data, exp_now.rd_data);
        if (exp_now.redirect) check_value("redirect_pc", redirect_pc, exp_now.redirect_pc);
        checked_count++;
      end
    end
  end

  task automatic end_test(input string name);
    test_count++;
    if (error_count == errors_at_start) begin
      $display("test %s: ok", name);
    end else begin
      failed_tests++;
      $display("test %s: %0d errors", name, error_count - errors_at_start);
    end
    errors_at_start = error_count;
  endtask

  // ######################################################################
  // stimulus
  // ######################################################################

  // called 1 ns after an edge with busy low.
  task automatic issue_instr(input logic is_ecall, input logic is_mret, input funct3_t f3,
      input csr_addr_t addr, input reg_index_t src, input word_t rs1, input word_t pc_val);
    int waited;
    check_value("busy", word_t'(busy), '0);
    exp_q.push_back(reference_result(is_ecall, is_mret, f3, addr, src, rs1, pc_val,
                                     cyc + 64'd1));
    issued_count++;
    valid     = 1'b1;
    ecall     = is_ecall;
    mret      = is_mret;
    funct3    = f3;
    csr_addr  = addr;
    src_index = src;
    rs1_data  = rs1;
    pc        = pc_val;
    @(posedge clock);
    #1;
    valid  = 1'b0;
    check_value("busy", word_t'(busy), 32'd1); // raised by the accept edge.
    waited = 0;
    while (checked_count != issued_count && waited < done_limit) begin
      @(posedge clock);
      #1;
      waited++;
    end
    if (checked_count != issued_count) begin
      error_count++;
      $display("no done within %0d cycles for the instruction at pc %h", done_limit, pc_val);
      exp_q.delete();
      checked_count = issued_count;
    end
  endtask

  task automatic read_csr(input csr_addr_t addr);
    issue_instr(1'b0, 1'b0, funct_csrrs, addr, '0, take_bits(32), random_pc());
  endtask

  task automatic write_csr(input csr_addr_t addr, input word_t value);
    issue_instr(1'b0, 1'b0, funct_csrrw, addr, 5'd1, value, random_pc());
  endtask

  function automatic funct3_t pick_funct(input int sel);
    case (sel)
      0:       return funct_csrrw;
      1:       return funct_csrrs;
      2:       return funct_csrrc;
      3:       return funct_csrrwi;
      4:       return funct_csrrsi;
      default: return funct_csrrci;
    endcase
  endfunction

  task automatic run_csr_ops();
    int         i;
    csr_addr_t  addr;
    reg_index_t src;
    for (i = 0; i < n_random_ops; i++) begin
      case (take_bits(2))
        0:       addr = csr_mstatus;
        1:       addr = csr_mtvec;
        2:       addr = csr_mepc;
        default: addr = csr_mcause;
      endcase
      src = (take_bits(2) == 0) ? '0 : reg_index_t'(take_bits(5));
      issue_instr(1'b0, 1'b0, pick_funct(int'(take_bits(3) % 6)), addr, src,
                  take_bits(32), random_pc());
    end
    // zero sources must leave the registers alone.
    issue_instr(1'b0, 1'b0, funct_csrrs, csr_mtvec, '0, take_bits(32), random_pc());
    issue_instr(1'b0, 1'b0, funct_csrrc, csr_mtvec, '0, take_bits(32), random_pc());
    // zero uimm on read-only csrs is still legal.
    issue_instr(1'b0, 1'b0, funct_csrrsi, csr_mvendorid, '0, '0, random_pc());
    issue_instr(1'b0, 1'b0, funct_csrrci, csr_marchid, '0, '0, random_pc());
  endtask

  task automatic run_counters();
    write_csr(csr_minstret, take_bits(32));
    read_csr(csr_mstatus);
    read_csr(csr_mstatus);
    read_csr(csr_mstatus);
    read_csr(csr_minstret);
    write_csr(csr_minstreth, take_bits(32));
    read_csr(csr_minstreth);
    read_csr(csr_minstret);
    read_csr(csr_mcycle);
    repeat (5) @(posedge clock);
    #1;
    read_csr(csr_mcycle);
    read_csr(csr_mcycleh);
    issue_instr(1'b1, 1'b0, '0, '0, '0, '0, random_pc()); // traps do not retire.
    read_csr(csr_minstret);
  endtask

  initial begin
    watchdog_loop: begin
      repeat (reset_cycles + watchdog_cycles) @(posedge clock);
    end
    $display("timeout: the run did not finish in %0d cycles", watchdog_cycles);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    reset = 1'b1;
    valid = 1'b0;
    ecall = 1'b0;
    mret = 1'b0;
    funct3 = '0;
    csr_addr = '0;
    src_index = '0;
    rs1_data = '0;
    pc = '0;
    m_mstatus = '0;
    m_mtvec = '0;
    m_mepc = '0;
    m_mcause = '0;
    m_minstret = '0;
    repeat (reset_cycles) @(posedge clock);
    #1;
    reset = 1'b0;

    check_value("busy", word_t'(busy), '0);
    check_value("done", word_t'(done), '0);
    read_csr(csr_mstatus);
    read_csr(csr_mtvec);
    read_csr(csr_mepc);
    read_csr(csr_mcause);
    read_csr(csr_mvendorid);
    read_csr(csr_marchid);
    end_test("reset state");

    run_csr_ops();
    end_test("csr operations");

    write_csr(csr_mtvec, take_bits(32));
    issue_instr(1'b0, 1'b0, funct_csrrsi, csr_mstatus, 5'd8, '0, random_pc()); // mie on.
    issue_instr(1'b1, 1'b0, '0, '0, '0, '0, random_pc());
    read_csr(csr_mcause);
    read_csr(csr_mepc);
    read_csr(csr_mstatus);
    end_test("ecall");

    write_csr(csr_mepc, random_pc());
    issue_instr(1'b0, 1'b1, '0, '0, '0, '0, random_pc());
    read_csr(csr_mstatus);
    end_test("mret");

    read_csr(12'h7c0);
    write_csr(12'h344, take_bits(32));
    write_csr(csr_mvendorid, take_bits(32));
    issue_instr(1'b0, 1'b0, funct_csrrsi, csr_marchid, 5'd1, '0, random_pc());
    read_csr(csr_mvendorid);
    read_csr(csr_mcause);
    read_csr(csr_mepc);
    end_test("illegal instructions");

    run_counters();
    end_test("counters");

    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             test_count, failed_tests, check_count, error_count);
    if (error_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== exu_sys.f ====
src/sys_pkg.sv
src/csr_alu.sv
src/csr_file.sv
src/csr_counters.sv
src/sys_ctrl.sv
src/exu_sys.sv
verif/exu_sys_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= exu_sys_tb
FILELIST  ?= exu_sys.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "Some tests failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
